//--- source/decode_pkg.sv
// RV64 integer encodings only; compressed, float and vector opcodes all decode as OP_UNKNOWN
package decode_pkg;

    // register value and pc width
    localparam int XLEN = 64;
    // uncompressed instruction width
    localparam int ILEN = 32;
    // architectural register index
    localparam int REG_IDX_W = 5;
    // x0 .. x31
    localparam int NUM_REGS = 32;

    // major opcode and func3 widths
    localparam int MAJOR_W = 7;
    localparam int FUNC3_W = 3;
    // func3 sits above the major opcode in the combined field
    localparam int OPCODE_W = FUNC3_W + MAJOR_W;

    // lui/auipc upper immediate, or the jal offset bits
    localparam int UIMM_W = 20;
    // raw instr[31:20]
    localparam int IMM12_W = 12;

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [ILEN-1:0]      instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [OPCODE_W-1:0]  opcode_t;
    typedef logic [UIMM_W-1:0]    uimm_t;
    typedef logic [IMM12_W-1:0]   imm12_t;

    // major opcode classes, encoded with their instr[6:0] value
    // 7'b0000000 is not a valid major opcode, so it marks unknown
    typedef enum logic [MAJOR_W-1:0] {
        OP_UNKNOWN      = 7'b0000000,
        OP_LOAD         = 7'b0000011,
        OP_FENCE        = 7'b0001111,
        OP_ALU_IMM      = 7'b0010011,
        OP_AUIPC        = 7'b0010111,
        OP_ALU_IMM_WORD = 7'b0011011,
        OP_STORE        = 7'b0100011,
        OP_R            = 7'b0110011,
        OP_LUI          = 7'b0110111,
        OP_R_WORD       = 7'b0111011,
        OP_BRANCH       = 7'b1100011,
        OP_JALR         = 7'b1100111,
        OP_JAL          = 7'b1101111,
        OP_SYSTEM       = 7'b1110011
    } op_class_e;

    // fence with func3 0, the downstream stages treat it as a nop
    localparam opcode_t BUBBLE_OPCODE = 10'h00f;

endpackage

//--- source/decode_fields_if.sv
// purely combinational bundle from instr, no clock and no handshake
interface decode_fields_if;

    // source indices, zero when the class does not read that register
    decode_pkg::reg_idx_t rs1_idx;
    decode_pkg::reg_idx_t rs2_idx;
    // destination, zero for store, branch, fence and unknown
    decode_pkg::reg_idx_t rd_idx;
    // {func3, major opcode}
    decode_pkg::opcode_t  opcode;
    // upper immediate for lui/auipc, scrambled offset for jal
    decode_pkg::uimm_t    uimm;
    // load or store
    logic                 mem_op;

    modport producer (
        output rs1_idx,
        output rs2_idx,
        output rd_idx,
        output opcode,
        output uimm,
        output mem_op
    );

    modport consumer (
        input rs1_idx,
        input rs2_idx,
        input rd_idx,
        input opcode,
        input uimm,
        input mem_op
    );

endinterface

//--- source/instr_field_decoder.sv
// decodes major opcode only; func3/func7 are passed through, illegal encodings are not flagged
module instr_field_decoder (
    input  decode_pkg::instr_t  instr,
    decode_fields_if.producer   fields
);

    decode_pkg::op_class_e op_class;
    // per-class register usage
    logic                  uses_rs1;
    logic                  uses_rs2;
    logic                  writes_rd;

    // classify by instr[6:0]
    always_comb begin
        case (instr[6:0])
            decode_pkg::OP_R:            op_class = decode_pkg::OP_R;
            decode_pkg::OP_R_WORD:       op_class = decode_pkg::OP_R_WORD;
            decode_pkg::OP_LOAD:         op_class = decode_pkg::OP_LOAD;
            decode_pkg::OP_ALU_IMM:      op_class = decode_pkg::OP_ALU_IMM;
            decode_pkg::OP_ALU_IMM_WORD: op_class = decode_pkg::OP_ALU_IMM_WORD;
            decode_pkg::OP_STORE:        op_class = decode_pkg::OP_STORE;
            decode_pkg::OP_BRANCH:       op_class = decode_pkg::OP_BRANCH;
            decode_pkg::OP_LUI:          op_class = decode_pkg::OP_LUI;
            decode_pkg::OP_AUIPC:        op_class = decode_pkg::OP_AUIPC;
            decode_pkg::OP_JAL:          op_class = decode_pkg::OP_JAL;
            decode_pkg::OP_JALR:         op_class = decode_pkg::OP_JALR;
            decode_pkg::OP_FENCE:        op_class = decode_pkg::OP_FENCE;
            decode_pkg::OP_SYSTEM:       op_class = decode_pkg::OP_SYSTEM;
            default:                     op_class = decode_pkg::OP_UNKNOWN;
        endcase
    end

    // register usage per class
    always_comb begin
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b0;
        writes_rd = 1'b1;
        case (op_class)
            // two-source register ops
            decode_pkg::OP_R,
            decode_pkg::OP_R_WORD: begin
                uses_rs2 = 1'b1;
            end
            // rs2 is the store data or the compare operand, no rd
            decode_pkg::OP_STORE,
            decode_pkg::OP_BRANCH: begin
                uses_rs2  = 1'b1;
                writes_rd = 1'b0;
            end
            // no source register at all
            decode_pkg::OP_LUI,
            decode_pkg::OP_AUIPC,
            decode_pkg::OP_JAL: begin
                uses_rs1 = 1'b0;
            end
            // rs1/rd fields of fence are reserved
            decode_pkg::OP_FENCE,
            decode_pkg::OP_UNKNOWN: begin
                uses_rs1  = 1'b0;
                writes_rd = 1'b0;
            end
            // load, alu-imm, jalr, system: rs1 and rd only
            default: begin
                uses_rs1  = 1'b1;
            end
        endcase
    end

    // field extraction
    always_comb begin
        fields.rs1_idx = uses_rs1  ? instr[19:15] : '0;
        // immediate bits in [24:20] must not look like a source
        fields.rs2_idx = uses_rs2  ? instr[24:20] : '0;
        fields.rd_idx  = writes_rd ? instr[11:7]  : '0;
        fields.opcode  = {instr[14:12], instr[6:0]};
        fields.mem_op  = (op_class == decode_pkg::OP_LOAD) ||
                         (op_class == decode_pkg::OP_STORE);

        case (op_class)
            decode_pkg::OP_LUI,
            decode_pkg::OP_AUIPC: begin
                fields.uimm = instr[31:12];
            end
            // jal offset[20|10:1|11|19:12] reordered to offset[20:1]
            decode_pkg::OP_JAL: begin
                fields.uimm = {instr[31], instr[19:12], instr[20], instr[30:21]};
            end
            default: begin
                fields.uimm = '0;
            end
        endcase
    end

endmodule

//--- source/hazard_detector.sv
// no forwarding assumed; any in-flight match stalls, alu stores are exempt as they write no reg
module hazard_detector (
    decode_fields_if.consumer    fields,
    input  decode_pkg::reg_idx_t alu_dest,
    input  decode_pkg::reg_idx_t mem_dest,
    input  decode_pkg::reg_idx_t wb_dest,
    input  logic                 alu_is_store,
    input  logic                 mem_busy,
    output logic                 stall_req
);

    logic alu_hit;
    logic mem_hit;
    logic wb_hit;

    // x0 never creates a dependency
    function automatic logic src_match(
        input decode_pkg::reg_idx_t dest,
        input decode_pkg::reg_idx_t rs1,
        input decode_pkg::reg_idx_t rs2
    );
        logic nonzero;
        nonzero = (dest != '0);
        return nonzero && ((dest == rs1) || (dest == rs2));
    endfunction

    always_comb begin
        // store in alu carries no destination
        alu_hit = src_match(alu_dest, fields.rs1_idx, fields.rs2_idx) && !alu_is_store;
        mem_hit = src_match(mem_dest, fields.rs1_idx, fields.rs2_idx);
        // writeback lands on the same edge, regfile has no bypass
        wb_hit  = src_match(wb_dest, fields.rs1_idx, fields.rs2_idx);

        stall_req = alu_hit || mem_hit || wb_hit || mem_busy;
    end

endmodule

//--- source/register_file.sv
// one write port, two async read ports; a write is seen by reads only after its clock edge
module register_file (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wr_en,
    input  decode_pkg::reg_idx_t wr_reg,
    input  decode_pkg::xlen_t    wr_data,
    decode_fields_if.consumer    fields,
    output decode_pkg::xlen_t    rs1_value,
    output decode_pkg::xlen_t    rs2_value
);

    decode_pkg::xlen_t regs [decode_pkg::NUM_REGS];

    // write port
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < decode_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_reg != '0)) begin
            // x0 writes dropped here
            regs[wr_reg] <= wr_data;
        end
    end

    // read ports, current contents only
    // x0 forced to zero on the read side as well
    always_comb begin
        if (fields.rs1_idx == '0) begin
            rs1_value = '0;
        end else begin
            rs1_value = regs[fields.rs1_idx];
        end

        if (fields.rs2_idx == '0) begin
            rs2_value = '0;
        end else begin
            rs2_value = regs[fields.rs2_idx];
        end
    end

endmodule

//--- source/decode_stage.sv
// one-cycle decode stage; stall is a bubble only, the fetch side must hold instr and pc itself
module decode_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  decode_pkg::instr_t   instr,
    input  decode_pkg::xlen_t    pc,
    input  logic                 wr_en,
    input  decode_pkg::reg_idx_t wr_reg,
    input  decode_pkg::xlen_t    wr_data,
    input  decode_pkg::reg_idx_t alu_dest,
    input  decode_pkg::reg_idx_t mem_dest,
    input  decode_pkg::reg_idx_t wb_dest,
    input  logic                 alu_is_store,
    input  logic                 mem_busy,
    input  logic                 flush,
    input  logic                 fetch_miss,
    input  logic                 icache_hit,
    output decode_pkg::xlen_t    rs1_data,
    output decode_pkg::xlen_t    rs2_data,
    output decode_pkg::reg_idx_t dest_reg,
    output decode_pkg::reg_idx_t rs1_idx,
    output decode_pkg::imm12_t   imm12,
    output decode_pkg::uimm_t    uimm,
    output decode_pkg::opcode_t  opcode,
    output decode_pkg::instr_t   instr_out,
    output decode_pkg::xlen_t    pc_out,
    output logic                 stall,
    output logic                 icache_hit_out,
    output logic                 mem_op
);

    decode_fields_if fields ();

    decode_pkg::xlen_t    rs1_value;
    decode_pkg::xlen_t    rs2_value;
    logic                 stall_req;
    // bubble this edge, new hazard or one already in progress
    logic                 hold;
    decode_pkg::reg_idx_t next_dest;
    // flush seen on the previous edge
    logic                 prev_flush;

    instr_field_decoder i_instr_field_decoder (
        .instr  (instr),
        .fields (fields.producer)
    );

    hazard_detector i_hazard_detector (
        .fields       (fields.consumer),
        .alu_dest     (alu_dest),
        .mem_dest     (mem_dest),
        .wb_dest      (wb_dest),
        .alu_is_store (alu_is_store),
        .mem_busy     (mem_busy),
        .stall_req    (stall_req)
    );

    // write port keeps running through stalls
    register_file i_register_file (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_reg    (wr_reg),
        .wr_data   (wr_data),
        .fields    (fields.consumer),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    assign hold = stall_req || stall;

    // first step, squash rd of a flushed or stalled slot
    assign next_dest = (flush || stall) ? '0 : fields.rd_idx;

    always_ff @(posedge clk) begin
        if (reset) begin
            rs1_data       <= '0;
            rs2_data       <= '0;
            dest_reg       <= '0;
            rs1_idx        <= '0;
            imm12          <= '0;
            uimm           <= '0;
            opcode         <= '0;
            instr_out      <= '0;
            pc_out         <= '0;
            stall          <= 1'b0;
            icache_hit_out <= 1'b0;
            mem_op         <= 1'b0;
            prev_flush     <= 1'b0;
        end else begin
            // pass-through fields update every cycle
            instr_out      <= instr;
            pc_out         <= pc;
            rs1_idx        <= fields.rs1_idx;
            imm12          <= instr[31:20];
            icache_hit_out <= icache_hit;
            stall          <= stall_req;
            prev_flush     <= flush;

            // second step, late squash for fetch miss or a flush one edge back
            dest_reg <= (fetch_miss || prev_flush) ? '0 : next_dest;

            if (hold) begin
                // bubble, operands and uimm keep their last values
                opcode <= decode_pkg::BUBBLE_OPCODE;
                mem_op <= 1'b0;
            end else begin
                opcode   <= fields.opcode;
                mem_op   <= fields.mem_op;
                uimm     <= fields.uimm;
                rs1_data <= rs1_value;
                rs2_data <= rs2_value;
            end
        end
    end

endmodule

//--- tb/tb_decode_stage.sv
// drives on falling edges and checks one cycle later; only the thirteen known major opcodes are generated
module tb_decode_stage;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TEST_COUNT      = 5;
    localparam int CYCLES_PER_TEST = 300;
    // worst case per test plus reset and drain
    localparam int CYCLE_LIMIT     = TEST_COUNT * CYCLES_PER_TEST + 100;
    localparam int RUN_LENGTH      = 200;
    localparam logic [31:0] SEED   = 32'd29706;

    // major opcodes of the thirteen classes
    localparam logic [12:0][6:0] MAJORS = {
        7'h33, 7'h3b, 7'h03, 7'h13, 7'h1b, 7'h23, 7'h63,
        7'h37, 7'h17, 7'h6f, 7'h67, 7'h0f, 7'h73
    };

    logic clk;
    logic reset;
    decode_pkg::instr_t   instr;
    decode_pkg::xlen_t    pc;
    logic                 wr_en;
    decode_pkg::reg_idx_t wr_reg;
    decode_pkg::xlen_t    wr_data;
    decode_pkg::reg_idx_t alu_dest;
    decode_pkg::reg_idx_t mem_dest;
    decode_pkg::reg_idx_t wb_dest;
    logic                 alu_is_store;
    logic                 mem_busy;
    logic                 flush;
    logic                 fetch_miss;
    logic                 icache_hit;
    decode_pkg::xlen_t    rs1_data;
    decode_pkg::xlen_t    rs2_data;
    decode_pkg::reg_idx_t dest_reg;
    decode_pkg::reg_idx_t rs1_idx;
    decode_pkg::imm12_t   imm12;
    decode_pkg::uimm_t    uimm;
    decode_pkg::opcode_t  opcode;
    decode_pkg::instr_t   instr_out;
    decode_pkg::xlen_t    pc_out;
    logic                 stall;
    logic                 icache_hit_out;
    logic                 mem_op;

    // model copy of the register file; x0 is never written
    decode_pkg::xlen_t    m_regs [decode_pkg::NUM_REGS];
    logic                 m_stall = 1'b0;
    logic                 m_prev_flush = 1'b0;
    // expected outputs after the next rising edge
    // initial values are the reset state
    decode_pkg::xlen_t    exp_rs1_data = '0;
    decode_pkg::xlen_t    exp_rs2_data = '0;
    decode_pkg::xlen_t    exp_pc = '0;
    decode_pkg::reg_idx_t exp_dest = '0;
    decode_pkg::reg_idx_t exp_rs1_idx = '0;
    decode_pkg::imm12_t   exp_imm12 = '0;
    decode_pkg::uimm_t    exp_uimm = '0;
    decode_pkg::opcode_t  exp_opcode = '0;
    decode_pkg::instr_t   exp_instr = '0;
    logic                 exp_stall = 1'b0;
    logic                 exp_icache = 1'b0;
    logic                 exp_mem_op = 1'b0;

    logic [31:0] lcg_state;
    int          checks = 0;
    int          errors = 0;
    int          cycle_count = 0;

    decode_stage i_decode_stage (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ends the run once the cycle limit is reached
    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Errors found");
        $finish;
    end

    // two lcg steps give one word from their upper halves
    function automatic logic [31:0] rand32();
        logic [15:0] hi;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        hi = lcg_state[31:16];
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {hi, lcg_state[31:16]};
    endfunction

    // reference decode of the class-dependent fields
    function automatic void decode_model(
        input  decode_pkg::instr_t   ins,
        output decode_pkg::reg_idx_t rs1,
        output decode_pkg::reg_idx_t rs2,
        output decode_pkg::reg_idx_t rd,
        output decode_pkg::uimm_t    u,
        output logic                 mem
    );
        rs1 = ins[19:15];
        rs2 = '0;
        rd  = ins[11:7];
        u   = '0;
        mem = 1'b0;
        case (ins[6:0])
            7'h33, 7'h3b: rs2 = ins[24:20];
            7'h23: begin
                rs2 = ins[24:20];
                rd  = '0;
                mem = 1'b1;
            end
            7'h63: begin
                rs2 = ins[24:20];
                rd  = '0;
            end
            7'h03: mem = 1'b1;
            7'h37, 7'h17: begin
                rs1 = '0;
                u   = ins[31:12];
            end
            // jal offset bits in order 20, 19:12, 11, 10:1
            7'h6f: begin
                rs1 = '0;
                u   = {ins[31], ins[19:12], ins[20], ins[30:21]};
            end
            7'h13, 7'h1b, 7'h67, 7'h73: begin
            end
            // fence and anything unknown
            default: begin
                rs1 = '0;
                rd  = '0;
            end
        endcase
    endfunction

    function automatic logic dest_hits(
        input decode_pkg::reg_idx_t d,
        input decode_pkg::reg_idx_t rs1,
        input decode_pkg::reg_idx_t rs2
    );
        return (d != '0) && ((d == rs1) || (d == rs2));
    endfunction

    task automatic check_data(input decode_pkg::xlen_t got, input decode_pkg::xlen_t exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg(input decode_pkg::reg_idx_t got, input decode_pkg::reg_idx_t exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
        end
    endtask

    task automatic check_opcode(input decode_pkg::opcode_t got, input decode_pkg::opcode_t exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_uimm(input decode_pkg::uimm_t got, input decode_pkg::uimm_t exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_imm12(input decode_pkg::imm12_t got, input decode_pkg::imm12_t exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_instr(input decode_pkg::instr_t got, input decode_pkg::instr_t exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_outputs();
        check_data(rs1_data, exp_rs1_data, "rs1_data");
        check_data(rs2_data, exp_rs2_data, "rs2_data");
        check_data(pc_out, exp_pc, "pc_out");
        check_reg(dest_reg, exp_dest, "dest_reg");
        check_reg(rs1_idx, exp_rs1_idx, "rs1_idx");
        check_imm12(imm12, exp_imm12, "imm12");
        check_uimm(uimm, exp_uimm, "uimm");
        check_opcode(opcode, exp_opcode, "opcode");
        check_instr(instr_out, exp_instr, "instr_out");
        check_flag(stall, exp_stall, "stall");
        check_flag(icache_hit_out, exp_icache, "icache_hit_out");
        check_flag(mem_op, exp_mem_op, "mem_op");
    endtask

    // mode 0 idle, 1 read all, 2 regfile, 3 fields, 4 hazard, 5 flush and fetch miss
    task automatic drive_inputs(input int mode, input int idx);
        logic [31:0] r;
        logic [31:0] body;
        r    = rand32();
        body = rand32();
        instr        = {body[31:7], MAJORS[rand32() % 13]};
        pc           = {rand32(), rand32()};
        icache_hit   = r[31];
        wr_en        = r[30];
        // x0 targeted about one write in eight
        wr_reg       = (r[29:27] == 3'd0) ? 5'd0 : r[26:22];
        wr_data      = {rand32(), rand32()};
        alu_dest     = '0;
        mem_dest     = '0;
        wb_dest      = '0;
        alu_is_store = 1'b0;
        mem_busy     = 1'b0;
        flush        = 1'b0;
        fetch_miss   = 1'b0;
        case (mode)
            0: begin
                // addi x0, x0, 0
                instr = 32'h0000_0013;
                wr_en = 1'b0;
            end
            1: begin
                instr = {7'h00, 5'(31 - idx), 5'(idx), 3'b000, 5'd0, 7'h33};
                wr_en = 1'b0;
            end
            2: instr[6:0] = r[21] ? 7'h33 : 7'h23;
            4, 5: begin
                // small index range so matches are common
                instr[19:15] = {2'b00, body[2:0]};
                instr[24:20] = {2'b00, body[5:3]};
                alu_dest     = {2'b00, r[20:18]};
                mem_dest     = {2'b00, r[17:15]};
                wb_dest      = {2'b00, r[14:12]};
                alu_is_store = r[11];
                mem_busy     = (r[10:8] == 3'd0);
                if (mode == 5) begin
                    flush      = (r[7:6] == 2'd0);
                    fetch_miss = (r[5:4] == 2'd0);
                end
            end
            default: begin
            end
        endcase
    endtask

    // expected outputs for the coming edge and the model update
    task automatic predict();
        decode_pkg::reg_idx_t rs1;
        decode_pkg::reg_idx_t rs2;
        decode_pkg::reg_idx_t rd;
        decode_pkg::reg_idx_t next_dest;
        decode_pkg::uimm_t    u;
        logic                 mem;
        logic                 req;
        logic                 hold;
        decode_model(instr, rs1, rs2, rd, u, mem);
        req = (dest_hits(alu_dest, rs1, rs2) && !alu_is_store) ||
              dest_hits(mem_dest, rs1, rs2) || dest_hits(wb_dest, rs1, rs2) || mem_busy;
        hold = req || m_stall;
        exp_opcode = hold ? decode_pkg::BUBBLE_OPCODE : {instr[14:12], instr[6:0]};
        exp_mem_op = hold ? 1'b0 : mem;
        // operands and uimm hold through a bubble
        if (!hold) begin
            exp_uimm     = u;
            exp_rs1_data = m_regs[rs1];
            exp_rs2_data = m_regs[rs2];
        end
        next_dest   = (flush || m_stall) ? 5'd0 : rd;
        exp_dest    = (fetch_miss || m_prev_flush) ? 5'd0 : next_dest;
        exp_rs1_idx = rs1;
        exp_imm12   = instr[31:20];
        exp_instr   = instr;
        exp_pc      = pc;
        exp_stall   = req;
        exp_icache  = icache_hit;
        m_stall      = req;
        m_prev_flush = flush;
        // write lands after the reads above
        if (wr_en && (wr_reg != 5'd0)) begin
            m_regs[wr_reg] = wr_data;
        end
    endtask

    // starts on a falling edge and returns on the next one
    task automatic run_cycle(input int mode, input int idx);
        check_outputs();
        drive_inputs(mode, idx);
        predict();
        @(negedge clk);
    endtask

    task automatic run_test(input int num, input string name, input int mode, input int len);
        int errors_before;
        errors_before = errors;
        for (int i = 0; i < len; i++) begin
            run_cycle(mode, i);
        end
        // one idle slot checks the last cycle of this test
        run_cycle(0, 0);
        $display("test %0d %s: %0d errors", num, name, errors - errors_before);
    endtask

    initial begin
        lcg_state    = SEED;
        reset        = 1'b1;
        instr        = '0;
        pc           = '0;
        wr_en        = 1'b0;
        wr_reg       = '0;
        wr_data      = '0;
        alu_dest     = '0;
        mem_dest     = '0;
        wb_dest      = '0;
        alu_is_store = 1'b0;
        mem_busy     = 1'b0;
        flush        = 1'b0;
        fetch_miss   = 1'b0;
        icache_hit   = 1'b0;
        for (int i = 0; i < decode_pkg::NUM_REGS; i++) begin
            m_regs[i] = '0;
        end
        repeat (3) @(negedge clk);
        reset = 1'b0;
        // first check sees the reset values
        run_test(1, "reset and register readback", 1, decode_pkg::NUM_REGS);
        run_test(2, "register write and read", 2, RUN_LENGTH);
        run_test(3, "field decode", 3, RUN_LENGTH);
        run_test(4, "hazard stall", 4, RUN_LENGTH);
        run_test(5, "flush and fetch miss", 5, RUN_LENGTH);
        check_outputs();
        $display("%0d tests, %0d checks, %0d errors", TEST_COUNT, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- vlog.f
source/decode_pkg.sv
source/decode_fields_if.sv
source/instr_field_decoder.sv
source/hazard_detector.sv
source/register_file.sv
source/decode_stage.sv
tb/tb_decode_stage.sv
